// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes handled by this pipeline
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_t;

  // funct3 codes, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7, alt form selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // **************************************************************************
  // instruction word views
  // **************************************************************************

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    opcode_t               opcode;
  } i_type_t;

  // bits 31..20 are funct7/rs2 for OP, an immediate for OP_IMM
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } insn_u;

  // addi x0, x0, 0
  localparam insn_u NOP_INSN = 32'h0000_0013;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  localparam int ORDER_W = 16;

  // operand b source
  typedef enum logic {
    B_SEL_REG = 1'b0,
    B_SEL_IMM = 1'b1
  } b_sel_t;

  // decode to execute
  typedef struct packed {
    logic                                valid;
    logic                                illegal;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2_addr;
    logic [rv_isa_pkg::XLEN-1:0]         rs1_data;
    logic [rv_isa_pkg::XLEN-1:0]         rs2_data;
    logic [rv_isa_pkg::XLEN-1:0]         imm;
    rv_isa_pkg::alu_op_t                 alu_op;
    b_sel_t                              b_sel;
  } id_ex_t;

  // register write port
  typedef struct packed {
    logic                                en;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   addr;
    logic [rv_isa_pkg::XLEN-1:0]         data;
  } wport_t;

  // execute to result
  typedef struct packed {
    logic                                valid;
    logic                                illegal;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_addr;
    logic [rv_isa_pkg::XLEN-1:0]         rd_value;
  } ex_res_t;

  typedef struct packed {
    logic                                valid;
    logic                                illegal;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_addr;
    logic [rv_isa_pkg::XLEN-1:0]         rd_value;
    logic [ORDER_W-1:0]                  order;
  } retire_t;

  // pending write wins over older source data
  function automatic logic [rv_isa_pkg::XLEN-1:0] fwd_data(
    wport_t                              w,
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   addr,
    logic [rv_isa_pkg::XLEN-1:0]         data
  );
    if (w.en && addr != '0 && w.addr == addr)
    begin
      return w.data;
    end
    return data;
  endfunction

endpackage

// ==== rv_reg_file.sv ====
module rv_reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_rdata_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_rdata_o,
  input  rv_pipe_pkg::wport_t               wport_i
);
  import rv_isa_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 and out of range addresses read as zero
  function automatic logic [XLEN-1:0] read_port(logic [REG_ADDR_W-1:0] addr);
    if (addr == '0 || addr >= NUM_REGS)
    begin
      return '0;
    end
    return regs[addr[IDX_W-1:0]];
  endfunction

  always_comb
  begin
    rs1_rdata_o = read_port(rs1_addr_i);
    rs2_rdata_o = read_port(rs2_addr_i);
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wport_i.en && wport_i.addr < NUM_REGS)
    begin
      regs[wport_i.addr[IDX_W-1:0]] <= wport_i.data;
    end
  end

endmodule

// ==== rv_decode.sv ====
module rv_decode #(
  parameter int NUM_REGS = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              insn_valid_i,
  input  rv_isa_pkg::insn_u                 insn_i,
  input  rv_pipe_pkg::wport_t               wport_i,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       rs2_rdata_i,
  output rv_pipe_pkg::id_ex_t               id_ex_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  insn_u                 insn;
  alu_op_t               alu_op;
  b_sel_t                b_sel;
  logic [XLEN-1:0]       imm;
  logic                  use_rs1;
  logic                  use_rs2;
  logic                  use_rd;
  logic                  bad_enc;
  logic                  bad_reg;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  id_ex_t                id_ex_d;
  id_ex_t                id_ex_q;

  // funct3 to alu op, alt picks sub / sra
  function automatic alu_op_t f3_to_op(logic [2:0] f3, logic alt);
    alu_op_t op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      F3_AND:     op = ALU_AND;
      default:    op = ALU_ADD;
    endcase
    return op;
  endfunction

  // **************************************************************************
  // field decode
  // **************************************************************************

  always_comb
  begin
    // idle slots decode as a nop, so no register is touched
    insn    = insn_valid_i ? insn_i : NOP_INSN;
    alu_op  = ALU_ADD;
    b_sel   = B_SEL_REG;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    bad_enc = 1'b0;
    case (insn.r.opcode)
      OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
        alu_op  = f3_to_op(insn.r.funct3, insn.r.funct7 == F7_ALT);
        bad_enc = !(insn.r.funct7 == F7_BASE ||
                    (insn.r.funct7 == F7_ALT &&
                     (insn.r.funct3 == F3_ADD_SUB || insn.r.funct3 == F3_SRL_SRA)));
      end
      OP_IMM:
      begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        b_sel   = B_SEL_IMM;
        imm     = {{(XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};
        // only srai takes the alt form, addi never subtracts
        alu_op  = f3_to_op(insn.i.funct3,
                           insn.i.funct3 == F3_SRL_SRA && insn.i.imm12[11:5] == F7_ALT);
        if (insn.i.funct3 == F3_SLL)
        begin
          bad_enc = insn.i.imm12[11:5] != F7_BASE;
        end
        else if (insn.i.funct3 == F3_SRL_SRA)
        begin
          bad_enc = insn.i.imm12[11:5] != F7_BASE && insn.i.imm12[11:5] != F7_ALT;
        end
      end
      LUI:
      begin
        use_rd = 1'b1;
        b_sel  = B_SEL_IMM;
        alu_op = ALU_PASS_B;
        imm    = {insn.i.imm12, insn.i.rs1, insn.i.funct3, 12'h000};
      end
      default:
      begin
        bad_enc = 1'b1;
      end
    endcase

    // rv32e has only the low registers
    bad_reg = (use_rd  && insn.r.rd  >= NUM_REGS) ||
              (use_rs1 && insn.r.rs1 >= NUM_REGS) ||
              (use_rs2 && insn.r.rs2 >= NUM_REGS);

    rs1_addr = use_rs1 ? insn.r.rs1 : '0;
    rs2_addr = use_rs2 ? insn.r.rs2 : '0;
    rd_addr  = use_rd  ? insn.r.rd  : '0;
  end

  assign rs1_addr_o = rs1_addr;
  assign rs2_addr_o = rs2_addr;

  always_comb
  begin
    id_ex_d.valid    = insn_valid_i;
    id_ex_d.illegal  = bad_enc | bad_reg;
    id_ex_d.rd_addr  = rd_addr;
    id_ex_d.rs1_addr = rs1_addr;
    id_ex_d.rs2_addr = rs2_addr;
    // write one cycle ahead has not reached the register file yet
    id_ex_d.rs1_data = fwd_data(wport_i, rs1_addr, rs1_rdata_i);
    id_ex_d.rs2_data = fwd_data(wport_i, rs2_addr, rs2_rdata_i);
    id_ex_d.imm      = imm;
    id_ex_d.alu_op   = alu_op;
    id_ex_d.b_sel    = b_sel;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      id_ex_q.valid   <= 1'b0;
      id_ex_q.illegal <= 1'b0;
    end
    else
    begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

// ==== rv_execute.sv ====
module rv_execute (
  input  rv_pipe_pkg::id_ex_t  id_ex_i,
  input  rv_pipe_pkg::wport_t  wport_i,
  output rv_pipe_pkg::ex_res_t ex_res_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  logic [XLEN-1:0]    src_a;
  logic [XLEN-1:0]    rs2_data;
  logic [XLEN-1:0]    src_b;
  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    alu_res;

  // **************************************************************************
  // forwarding and operand select
  // **************************************************************************

  always_comb
  begin
    // producer one ahead sits in the result stage
    src_a    = fwd_data(wport_i, id_ex_i.rs1_addr, id_ex_i.rs1_data);
    rs2_data = fwd_data(wport_i, id_ex_i.rs2_addr, id_ex_i.rs2_data);
    src_b    = (id_ex_i.b_sel == B_SEL_IMM) ? id_ex_i.imm : rs2_data;
    shamt    = src_b[SHAMT_W-1:0];
  end

  // **************************************************************************
  // alu
  // **************************************************************************

  always_comb
  begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = src_a + src_b;
      ALU_SUB:    alu_res = src_a - src_b;
      ALU_SLL:    alu_res = src_a << shamt;
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, src_a < src_b};
      ALU_XOR:    alu_res = src_a ^ src_b;
      ALU_SRL:    alu_res = src_a >> shamt;
      ALU_SRA:    alu_res = $unsigned($signed(src_a) >>> shamt);
      ALU_OR:     alu_res = src_a | src_b;
      ALU_AND:    alu_res = src_a & src_b;
      ALU_PASS_B: alu_res = src_b;
      default:    alu_res = '0;
    endcase
  end

  always_comb
  begin
    ex_res_o.valid   = id_ex_i.valid;
    ex_res_o.illegal = id_ex_i.illegal;
    ex_res_o.rd_addr = id_ex_i.rd_addr;
    // no value leaves a dead or illegal slot
    ex_res_o.rd_value = (id_ex_i.valid && !id_ex_i.illegal) ? alu_res : '0;
  end

endmodule

// ==== rv_result.sv ====
module rv_result (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rv_pipe_pkg::ex_res_t ex_res_i,
  output rv_pipe_pkg::wport_t  wport_o,
  output rv_pipe_pkg::retire_t retire_o
);
  import rv_pipe_pkg::*;

  retire_t            ret_q;
  logic [ORDER_W-1:0] order_cnt;
  logic               no_write;

  // illegal and x0 results retire with a zero value
  assign no_write = ex_res_i.illegal || ex_res_i.rd_addr == '0;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ret_q.valid   <= 1'b0;
      ret_q.illegal <= 1'b0;
      ret_q.order   <= '0;
      order_cnt     <= '0;
    end
    else
    begin
      ret_q.valid    <= ex_res_i.valid;
      ret_q.illegal  <= ex_res_i.illegal;
      ret_q.rd_addr  <= ex_res_i.rd_addr;
      ret_q.rd_value <= no_write ? '0 : ex_res_i.rd_value;
      ret_q.order    <= order_cnt;
      // count of retires so far, tags the next one
      if (ex_res_i.valid)
      begin
        order_cnt <= order_cnt + 1'b1;
      end
    end
  end

  // write port, also feeds forwarding and the decode bypass
  always_comb
  begin
    wport_o.en   = ret_q.valid && !ret_q.illegal && ret_q.rd_addr != '0;
    wport_o.addr = ret_q.rd_addr;
    wport_o.data = ret_q.rd_value;
  end

  assign retire_o = ret_q;

endmodule

// ==== rv_core.sv ====
module rv_core #(
  parameter int NUM_REGS = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 insn_valid_i,
  input  rv_isa_pkg::insn_u    insn_i,
  output rv_pipe_pkg::retire_t retire_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  id_ex_t                id_ex;
  ex_res_t               ex_res;
  wport_t                wport;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_rdata;
  logic [XLEN-1:0]       rs2_rdata;

  // **************************************************************************
  // decode, execute, result
  // **************************************************************************

  rv_decode #(
    .NUM_REGS     (NUM_REGS)
  ) u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .insn_valid_i (insn_valid_i),
    .insn_i       (insn_i),
    .wport_i      (wport),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_rdata_i  (rs1_rdata),
    .rs2_rdata_i  (rs2_rdata),
    .id_ex_o      (id_ex)
  );

  rv_execute u_execute (
    .id_ex_i      (id_ex),
    .wport_i      (wport),
    .ex_res_o     (ex_res)
  );

  rv_result u_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ex_res_i     (ex_res),
    .wport_o      (wport),
    .retire_o     (retire_o)
  );

  // single write port, driven from the result stage
  rv_reg_file #(
    .NUM_REGS     (NUM_REGS)
  ) u_reg_file (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rs1_addr_i   (rs1_addr),
    .rs2_addr_i   (rs2_addr),
    .rs1_rdata_o  (rs1_rdata),
    .rs2_rdata_o  (rs2_rdata),
    .wport_i      (wport)
  );

endmodule

// ==== rv_core_chk.sv ====
module rv_core_chk (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 insn_valid_i,
  input  rv_pipe_pkg::wport_t  wport_i,
  input  rv_pipe_pkg::retire_t retire_i
);
  import rv_pipe_pkg::*;

  // order tag expected on the next retire
  logic [ORDER_W-1:0] next_order;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      next_order <= '0;
    end
    else if (retire_i.valid)
    begin
      next_order <= retire_i.order + 1'b1;
    end
  end

  // x0 is never written
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wport_i.en |-> wport_i.addr != '0)
    else $error("write port enabled with address 0");

  // fixed two cycle latency, no drops and no extras
  a_retire_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_i.valid == $past(insn_valid_i, 2))
    else $error("retire valid does not follow the instruction strobe by two cycles");

  a_order_step: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_i.valid |-> retire_i.order == next_order)
    else $error("order count did not step by one");

endmodule

// ==== tb_rv_core.sv ====
module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int          CLK_HALF   = 20;
  localparam int          RST_CYCLES = 4;
  localparam int          DRIVE_DLY  = 2;
  localparam logic [15:0] LFSR_SEED  = 16'd19;

  // one line of the golden file
  typedef struct packed {
    insn_u                 insn;
    logic                  illegal;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       value;
  } vec_t;

  logic        clk_i;
  logic        rst_i;
  logic        insn_valid;
  insn_u       insn;
  retire_t     retire;
  vec_t        vectors[$];
  vec_t        expect_q[$];
  vec_t        head;
  int          retired;
  logic        loaded;
  logic [15:0] lfsr;

  rv_core #(
    .NUM_REGS     (32)
  ) uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .insn_valid_i (insn_valid),
    .insn_i       (insn),
    .retire_o     (retire)
  );

  bind rv_core rv_core_chk u_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .insn_valid_i (insn_valid_i),
    .wport_i      (wport),
    .retire_i     (retire_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // **************************************************************************
  // helpers
  // **************************************************************************

  // galois form with taps at 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_write(retire_t got, vec_t exp);
    if (got.rd_addr !== exp.rd)
    begin
      report_mismatch("retire_o.rd_addr", got.rd_addr, exp.rd);
    end
    else if (got.rd_value !== exp.value)
    begin
      report_mismatch("retire_o.rd_value", got.rd_value, exp.value);
    end
  endtask

  // illegal slots must carry a zero value
  task automatic check_illegal(retire_t got, vec_t exp);
    if (got.illegal !== exp.illegal)
    begin
      report_mismatch("retire_o.illegal", got.illegal, exp.illegal);
    end
    else if (exp.illegal && got.rd_value !== '0)
    begin
      report_mismatch("retire_o.rd_value", got.rd_value, '0);
    end
  endtask

  task automatic check_order(logic [ORDER_W-1:0] got, int index);
    if (got !== index[ORDER_W-1:0])
    begin
      report_mismatch("retire_o.order", got, index);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_insn;
    logic [31:0] f_ill;
    logic [31:0] f_rd;
    logic [31:0] f_val;
    vec_t        v;
    fd = $fopen("rv_core_golden.txt", "r");
    if (fd == 0)
    begin
      fail_run("cannot open rv_core_golden.txt");
    end
    else
    begin
      // comment and blank lines do not scan as four fields
      while ($fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%h %h %h %h", f_insn, f_ill, f_rd, f_val);
        if (n == 4)
        begin
          v.insn    = f_insn;
          v.illegal = f_ill[0];
          v.rd      = f_rd[REG_ADDR_W-1:0];
          v.value   = f_val;
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  // **************************************************************************
  // stimulus
  // **************************************************************************

  initial
  begin
    logic gap;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    insn_valid  = 1'b0;
    insn        = NOP_INSN;
    lfsr        = LFSR_SEED;
    retired     = 0;
    loaded      = 1'b0;
    load_vectors();
    if (vectors.size() == 0)
    begin
      fail_run("golden file holds no instructions");
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    foreach (vectors[i])
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
      take_bit(gap);
      // each set lfsr bit leaves one cycle idle
      while (gap)
      begin
        insn_valid = 1'b0;
        insn       = NOP_INSN;
        @(posedge clk_i);
        #DRIVE_DLY;
        take_bit(gap);
      end
      insn_valid = 1'b1;
      insn       = vectors[i].insn;
      expect_q.push_back(vectors[i]);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    insn_valid = 1'b0;
    insn       = NOP_INSN;
    wait (retired == vectors.size());
    // a few idle cycles to catch a stray retire
    repeat (3) @(posedge clk_i);
    $display("Everything OK");
    $finish;
  end

  // retire monitor sampled away from the active edge
  always @(negedge clk_i)
  begin
    if (!rst_i && retire.valid)
    begin
      if (expect_q.size() == 0)
      begin
        fail_run("an instruction retired that was never issued");
      end
      else
      begin
        head = expect_q.pop_front();
        check_illegal(retire, head);
        if (!head.illegal)
        begin
          check_write(retire, head);
        end
        check_order(retire.order, retired);
        retired++;
      end
    end
  end

  initial
  begin
    wait (loaded);
    repeat (4 * vectors.size() + 20) @(posedge clk_i);
    fail_run("timeout, not every instruction retired in time");
  end

endmodule

// ==== rv_core_golden.txt ====
# insn_word illegal rd value, all hex
# value is the expected retire value, rd is ignored for illegal lines
00500093 0 01 00000005  # addi x1, x0, 5
ffd00113 0 02 fffffffd  # addi x2, x0, -3
002081b3 0 03 00000002  # add  x3, x1, x2
40118233 0 04 fffffffd  # sub  x4, x3, x1
003092b3 0 05 00000014  # sll  x5, x1, x3
00112333 0 06 00000001  # slt  x6, x2, x1
001133b3 0 07 00000000  # sltu x7, x2, x1
00124433 0 08 fffffff8  # xor  x8, x4, x1
003454b3 0 09 3ffffffe  # srl  x9, x8, x3
40345533 0 0a fffffffe  # sra  x10, x8, x3
0062e5b3 0 0b 00000015  # or   x11, x5, x6
00a4f633 0 0c 3ffffffe  # and  x12, x9, x10
ffe12693 0 0d 00000001  # slti  x13, x2, -2
fff0b713 0 0e 00000001  # sltiu x14, x1, -1
7ff0c793 0 0f 000007fa  # xori  x15, x1, 0x7ff
8057e813 0 10 ffffffff  # ori   x16, x15, -2043
0f087893 0 11 000000f0  # andi  x17, x16, 0xf0
00489913 0 12 00000f00  # slli  x18, x17, 4
01c85993 0 13 0000000f  # srli  x19, x16, 28
40125a13 0 14 fffffffe  # srai  x20, x4, 1
abcdeab7 0 15 abcde000  # lui   x21, 0xabcde
123a8a93 0 15 abcde123  # addi  x21, x21, 0x123
00708013 0 00 00000000  # addi  x0, x1, 7
00100b33 0 16 00000005  # add   x22, x0, x1
021080b3 1 01 00000000  # mul x1, x1, x1 is not rv32i
ffffffff 1 00 00000000  # unknown opcode
00008bb3 0 17 00000005  # add   x23, x1, x0
40109093 1 01 00000000  # slli with bad upper bits
00008c13 0 18 00000005  # addi  x24, x1, 0
12345037 0 00 00000000  # lui   x0, 0x12345
00000cb3 0 19 00000000  # add   x25, x0, x0

// ==== rv_alu_pipe.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_reg_file.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_core.sv
rv_core_chk.sv
tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f rv_alu_pipe.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
